/* files.f */
+incdir+include
verilog/cdc_pkg.sv
verilog/cdc_afifo.sv
verilog/cdc_ingress.sv
verilog/cdc_egress.sv
verilog/cdc_bridge_top.sv
bench/cdc_bridge_tb.sv

/* Bender.yml */
package:
  name: cdc_bridge

sources:
  - include_dirs:
      - include
    files:
      - verilog/cdc_pkg.sv
      - verilog/cdc_afifo.sv
      - verilog/cdc_ingress.sv
      - verilog/cdc_egress.sv
      - verilog/cdc_bridge_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/cdc_bridge_tb.sv

/* bench/cdc_bridge_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "cdc_consts.svh"

module cdc_bridge_tb;

	import cdc_pkg::*;

	// Read clock unrelated to write clock
	localparam int WCLK_PERIOD  = 20;
	localparam int RCLK_PERIOD  = 28;
	localparam int DRV_DLY      = 2;
	localparam int RESET_CYCLES = 16;
	localparam int DATA_W       = `CDC_DATA_W;
	localparam int DEPTH        = 1 << `CDC_ASIZE;
	localparam int unsigned SEED = 32'hc8c6_3143;

	// Test budgets in write clock cycles
	localparam int LEN_RESET = 40;
	localparam int LEN_INTEG = 1600;
	localparam int LEN_DRAIN = 100;
	localparam int LEN_BACKP = 300;
	localparam int LEN_BURST = 400;
	localparam int LIMIT = 4 * (LEN_RESET + LEN_INTEG + LEN_DRAIN + LEN_BACKP + LEN_BURST);

	logic    i_wclk;
	logic    i_rclk;
	logic    i_rst_n;
	logic    i_valid;
	sample_t i_sample;
	logic    i_rd_credit;
	logic    o_credit;
	logic    o_valid;
	sample_t o_sample;
	logic    o_seq_err;

	// Reference model state
	logic [DATA_W-1:0] model_q[$];
	logic [DATA_W-1:0] exp_data;
	int unsigned sent;
	int unsigned returned;
	int unsigned delivered;
	int unsigned granted;
	int unsigned grants_pending;
	bit          grant_random;

	// Bookkeeping
	int unsigned cycles;
	int unsigned errors;
	int unsigned test_err0;
	int unsigned test_num;
	int unsigned tests_passed;
	int unsigned tests_failed;

	cdc_bridge_top UUT (
		.i_wclk      (i_wclk),
		.i_rclk      (i_rclk),
		.i_rst_n     (i_rst_n),
		.i_valid     (i_valid),
		.i_sample    (i_sample),
		.o_credit    (o_credit),
		.i_rd_credit (i_rd_credit),
		.o_valid     (o_valid),
		.o_sample    (o_sample),
		.o_seq_err   (o_seq_err)
	);

	always #(WCLK_PERIOD/2) i_wclk = ~i_wclk;
	always #(RCLK_PERIOD/2) i_rclk = ~i_rclk;

	////////////////////
	// Monitors
	////////////////////

	// Run limit
	always @(posedge i_wclk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout: run passed %0d write clock cycles", LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Upstream credits come back one pulse at a time
	always @(negedge i_wclk) begin
		if (o_credit === 1'b1) begin
			returned++;
			assert (returned <= sent) else begin
				$display("More credits returned than samples sent");
				errors++;
			end
		end
	end

	// Each delivered sample must match the model head
	always @(negedge i_rclk) begin
		if (o_valid === 1'b1) begin
			assert (model_q.size() != 0) else begin
				$display("o_valid pulsed with no sample outstanding in the model");
				errors++;
			end
			if (model_q.size() != 0) begin
				exp_data = model_q.pop_front();
				assert (o_sample.data === exp_data) else begin
					$display("ERROR: o_sample expected %h actual %h", exp_data, o_sample.data);
					errors++;
				end
			end
			delivered++;
			// Consumer never sees more than it granted
			assert (delivered <= granted) else begin
				$display("Sample delivered without a downstream credit");
				errors++;
			end
		end
	end

	// Downstream consumer serves queued grants before random ones
	always @(posedge i_rclk) begin
		#DRV_DLY;
		if (grants_pending > 0) begin
			i_rd_credit = 1'b1;
			grants_pending--;
			granted++;
		end else if (grant_random && $urandom_range(1, 0) == 1) begin
			i_rd_credit = 1'b1;
			granted++;
		end else begin
			i_rd_credit = 1'b0;
		end
	end

	////////////////////
	// Tasks
	////////////////////

	task automatic check_zero(input string name, input logic value);
		assert (value === 1'b0) else begin
			$display("ERROR: %s expected 0 actual %h", name, value);
			errors++;
		end
	endtask

	task automatic check_idle();
		check_zero("o_credit", o_credit);
		check_zero("o_valid", o_valid);
		check_zero("o_seq_err", o_seq_err);
	endtask

	task automatic check_count(input string name, input int unsigned act, input int unsigned exp);
		assert (act == exp) else begin
			$display("ERROR: %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// Consumer mode changes on a read edge ahead of the driver
	task automatic set_random_grants(input bit on);
		@(posedge i_rclk);
		grant_random = on;
	endtask

	task automatic grant_credits(input int unsigned n);
		@(posedge i_rclk);
		grants_pending = grants_pending + n;
	endtask

	// Reset held 16 write cycles and model cleared with it
	task automatic apply_reset(input bit check_outputs);
		int i;
		set_random_grants(1'b0);
		grants_pending = 0;
		@(posedge i_wclk);
		#DRV_DLY;
		i_rst_n = 1'b0;
		i_valid = 1'b0;
		model_q.delete();
		sent      = 0;
		returned  = 0;
		delivered = 0;
		granted   = `CDC_DOWN_CREDITS;
		for (i = 0; i < RESET_CYCLES; i++) begin
			@(negedge i_wclk);
			// Read side needs a few edges before its flops settle
			if (check_outputs && i >= 4)
				check_idle();
			@(posedge i_wclk);
		end
		#DRV_DLY;
		i_rst_n = 1'b1;
		@(negedge i_wclk);
		if (check_outputs)
			check_idle();
		// Read domain leaves reset 2 read cycles later
		repeat (4) @(posedge i_rclk);
	endtask

	// Producer sends only while it holds a credit
	task automatic send_samples(input int n, input bit gaps);
		int      done;
		sample_t s;
		done = 0;
		while (done < n) begin
			@(posedge i_wclk);
			#DRV_DLY;
			if ((sent - returned) < DEPTH && (!gaps || $urandom_range(3, 0) != 0)) begin
				s.data   = DATA_W'($urandom);
				i_valid  = 1'b1;
				i_sample = s;
				model_q.push_back(s.data);
				sent++;
				done++;
			end else begin
				i_valid = 1'b0;
			end
		end
		@(posedge i_wclk);
		#DRV_DLY;
		i_valid = 1'b0;
	endtask

	task automatic start_test();
		test_num++;
		test_err0 = errors;
	endtask

	task automatic finish_test(input string name);
		if (errors == test_err0) begin
			tests_passed++;
			$display("Test %0d %s: pass", test_num, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: fail, %0d errors", test_num, name, errors - test_err0);
		end
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		int unsigned base_ret;
		int unsigned base_del;
		i_wclk = 1'b0;
		i_rclk = 1'b0;
		i_rst_n = 1'b0;
		i_valid = 1'b0;
		i_sample = '0;
		i_rd_credit = 1'b0;
		grant_random = 1'b0;
		grants_pending = 0;
		granted = `CDC_DOWN_CREDITS;
		void'($urandom(SEED));

		// Outputs quiet in and just after reset
		start_test();
		apply_reset(1'b1);
		finish_test("reset state");

		// Random traffic both sides
		start_test();
		set_random_grants(1'b1);
		send_samples(400, 1'b1);
		wait (delivered == 400);
		set_random_grants(1'b0);
		check_count("model queue depth", model_q.size(), 0);
		check_zero("o_seq_err", o_seq_err);
		finish_test("ordered integrity");

		// Every sent sample returns one credit
		start_test();
		wait (returned == sent);
		repeat (20) @(posedge i_wclk);
		check_count("o_credit pulses", returned, sent);
		finish_test("upstream credit conservation");

		// Only the reset credits are spent without grants
		start_test();
		apply_reset(1'b0);
		send_samples(10, 1'b0);
		wait (delivered == `CDC_DOWN_CREDITS);
		repeat (60) @(posedge i_wclk);
		check_count("o_valid pulses", delivered, `CDC_DOWN_CREDITS);
		grant_credits(6);
		wait (delivered == 10);
		wait (returned == 10);
		check_count("model queue depth", model_q.size(), 0);
		check_zero("o_seq_err", o_seq_err);
		finish_test("downstream back-pressure");

		// Consumer out of credit while the FIFO fills to the brim
		start_test();
		base_ret = returned;
		base_del = delivered;
		check_count("downstream credits left", granted - delivered, 0);
		send_samples(DEPTH, 1'b0);
		check_count("upstream credits", DEPTH - (sent - returned), 0);
		repeat (60) @(posedge i_wclk);
		check_count("o_credit pulses", returned, base_ret);
		check_count("o_valid pulses", delivered, base_del);
		grant_credits(DEPTH);
		wait (delivered == base_del + DEPTH);
		wait (returned == base_ret + DEPTH);
		repeat (20) @(posedge i_wclk);
		check_count("o_credit pulses", returned - base_ret, DEPTH);
		check_count("model queue depth", model_q.size(), 0);
		check_zero("o_seq_err", o_seq_err);
		finish_test("full FIFO burst");

		$display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/cdc_bridge_top.sv */
`default_nettype none
`timescale 1ns/100ps

`include "cdc_consts.svh"

module cdc_bridge_top (
	input  wire logic              i_wclk,
	input  wire logic              i_rclk,
	// Synchronous to i_wclk
	input  wire logic              i_rst_n,
	// Upstream, write domain
	input  wire logic              i_valid,
	input  wire cdc_pkg::sample_t  i_sample,
	output logic                   o_credit,
	// Downstream, read domain
	input  wire logic              i_rd_credit,
	output logic                   o_valid,
	output cdc_pkg::sample_t       o_sample,
	output logic                   o_seq_err
);

	import cdc_pkg::*;

	// Ingress to FIFO
	logic              wr;
	cdc_word_t         wdata;
	logic [`CDC_ASIZE:0] rptr_sync;

	// FIFO to egress
	cdc_word_t rdata;
	logic      rempty_;
	logic      rd;
	logic      rrst_n;

	////////////////////
	// Write domain
	////////////////////

	cdc_ingress u_ingress (
		.i_wclk      (i_wclk),
		.i_rst_n     (i_rst_n),
		.i_valid     (i_valid),
		.i_sample    (i_sample),
		.o_credit    (o_credit),
		.i_rptr_sync (rptr_sync),
		.o_wr        (wr),
		.o_wdata     (wdata)
	);

	// Full flag unused, upstream credits cover the depth
	cdc_afifo #(
		.T     (cdc_word_t),
		.ASIZE (`CDC_ASIZE)
	) u_afifo (
		.i_wclk      (i_wclk),
		.i_rst_n     (i_rst_n),
		.i_wr        (wr),
		.i_wdata     (wdata),
		.o_wfull     (),
		.o_rptr_sync (rptr_sync),
		.i_rclk      (i_rclk),
		.i_rrst_n    (rrst_n),
		.i_rd        (rd),
		.o_rdata     (rdata),
		.o_rempty_   (rempty_)
	);

	////////////////////
	// Read domain
	////////////////////

	cdc_egress u_egress (
		.i_rclk      (i_rclk),
		.i_rst_n     (i_rst_n),
		.o_rrst_n    (rrst_n),
		.i_rempty_   (rempty_),
		.i_rdata     (rdata),
		.o_rd        (rd),
		.i_rd_credit (i_rd_credit),
		.o_valid     (o_valid),
		.o_sample    (o_sample),
		.o_seq_err   (o_seq_err)
	);

endmodule

`default_nettype wire

/* verilog/cdc_egress.sv */
`default_nettype none
`timescale 1ns/100ps

`include "cdc_consts.svh"

module cdc_egress (
	input  wire logic                i_rclk,
	// Write-domain reset, resynchronized here
	input  wire logic                i_rst_n,
	output logic                     o_rrst_n,
	// FIFO read port
	input  wire logic                i_rempty_,
	input  wire cdc_pkg::cdc_word_t  i_rdata,
	output logic                     o_rd,
	// Downstream consumer
	input  wire logic                i_rd_credit,
	output logic                     o_valid,
	output cdc_pkg::sample_t         o_sample,
	output logic                     o_seq_err
);

	// Room for credits granted well ahead of the data
	localparam int CRED_W = 10;

	// Reset synchronizer stages
	logic rrst_n_q1, rrst_n_q2;

	// Downstream credit balance
	logic [CRED_W-1:0] credit;
	logic              pop;

	// Next tag expected from the FIFO
	logic [`CDC_TAG_W-1:0] exp_tag;

	////////////////////
	// Reset into i_rclk
	////////////////////

	// Two flops, release lands 2 read cycles later
	always_ff @(posedge i_rclk) begin
		rrst_n_q1 <= i_rst_n;
		rrst_n_q2 <= rrst_n_q1;
	end

	assign o_rrst_n = rrst_n_q2;

	////////////////////
	// Pop decision
	////////////////////

	// Needs both a credit and a word
	assign pop  = (credit != '0) && i_rempty_;
	assign o_rd = pop;

	always_ff @(posedge i_rclk) begin
		if (!rrst_n_q2) begin
			credit <= CRED_W'(`CDC_DOWN_CREDITS);
		end else begin
			// Grant and spend may land on the same cycle
			case ({i_rd_credit, pop})
				2'b10:   credit <= credit + 1'b1;
				2'b01:   credit <= credit - 1'b1;
				default: credit <= credit;
			endcase
		end
	end

	////////////////////
	// Output and tag check
	////////////////////

	always_ff @(posedge i_rclk) begin
		if (!rrst_n_q2) begin
			o_valid   <= 1'b0;
			exp_tag   <= '0;
			o_seq_err <= 1'b0;
		end else begin
			o_valid <= pop;
			if (pop) begin
				exp_tag <= exp_tag + 1'b1;
				// Sticky until the next reset
				if (i_rdata.tag != exp_tag)
					o_seq_err <= 1'b1;
			end
		end
	end

	// Sample register, payload only
	always_ff @(posedge i_rclk) begin
		if (pop)
			o_sample <= i_rdata.sample;
	end

endmodule

`default_nettype wire

/* verilog/cdc_ingress.sv */
`default_nettype none
`timescale 1ns/100ps

`include "cdc_consts.svh"

module cdc_ingress (
	input  wire logic               i_wclk,
	input  wire logic               i_rst_n,
	// Upstream producer
	input  wire logic               i_valid,
	input  wire cdc_pkg::sample_t   i_sample,
	output logic                    o_credit,
	// FIFO write port
	input  wire logic [`CDC_ASIZE:0] i_rptr_sync,
	output logic                    o_wr,
	output cdc_pkg::cdc_word_t      o_wdata
);

	import cdc_pkg::*;

	// Pointer width, one extra bit for wrap
	localparam int PW = `CDC_ASIZE + 1;

	// Running sequence tag
	logic [`CDC_TAG_W-1:0] tag;
	cdc_word_t             word_next;

	// Credit return bookkeeping
	logic [PW-1:0] rptr_prev;
	logic [PW-1:0] rptr_adv;
	// One spare bit above the depth
	logic [PW:0]   pending;
	logic [PW:0]   pending_sum;

	////////////////////
	// Tagging
	////////////////////

	always_comb begin
		word_next.tag    = tag;
		word_next.sample = i_sample;
	end

	// Slots freed since last cycle, modulo pointer range
	assign rptr_adv    = i_rptr_sync - rptr_prev;
	assign pending_sum = pending + {1'b0, rptr_adv};

	////////////////////
	// Control state
	////////////////////

	always_ff @(posedge i_wclk) begin
		if (!i_rst_n) begin
			o_wr      <= 1'b0;
			tag       <= '0;
			rptr_prev <= '0;
			pending   <= '0;
			o_credit  <= 1'b0;
		end else begin
			// Credits already gate the producer, FIFO never full here
			o_wr <= i_valid;
			if (i_valid)
				tag <= tag + 1'b1;

			rptr_prev <= i_rptr_sync;

			// One credit back per cycle, the rest waits
			if (pending_sum != '0) begin
				o_credit <= 1'b1;
				pending  <= pending_sum - 1'b1;
			end else begin
				o_credit <= 1'b0;
				pending  <= pending_sum;
			end
		end
	end

	// Payload register
	always_ff @(posedge i_wclk) begin
		if (i_valid)
			o_wdata <= word_next;
	end

endmodule

`default_nettype wire

/* verilog/cdc_afifo.sv */
`default_nettype none
`timescale 1ns/100ps

`include "cdc_consts.svh"

module cdc_afifo #(
	parameter type T     = logic [7:0],
	parameter int  ASIZE = `CDC_ASIZE
) (
	// Write domain
	input  wire logic         i_wclk,
	input  wire logic         i_rst_n,
	input  wire logic         i_wr,
	input  wire T             i_wdata,
	output logic              o_wfull,
	output logic [ASIZE:0]    o_rptr_sync,
	// Read domain
	input  wire logic         i_rclk,
	input  wire logic         i_rrst_n,
	input  wire logic         i_rd,
	output T                  o_rdata,
	output logic              o_rempty_
);

	localparam int AW = ASIZE;

	// Storage, no reset on the payload
	T mem [0:(1<<AW)-1];

	// Write side pointers
	logic [AW:0]   wbin, wgray;
	logic [AW:0]   wbinnext, wgraynext;
	logic [AW-1:0] waddr;
	logic          wfull_next;
	logic [AW:0]   wq1_rgray, wq2_rgray;

	// Read side pointers
	logic [AW:0]   rbin, rgray;
	logic [AW:0]   rbinnext, rgraynext;
	logic [AW-1:0] raddr;
	logic          rempty__next;
	logic [AW:0]   rq1_wgray, rq2_wgray;

	// Gray to binary, each bit folds in all bits above it
	function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
		logic [AW:0] b;
		b[AW] = g[AW];
		for (int i = AW-1; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	////////////////////
	// Write clock domain
	////////////////////

	// Read Gray pointer enters the write domain through two flops
	always_ff @(posedge i_wclk) begin
		if (!i_rst_n) begin
			wq1_rgray <= '0;
			wq2_rgray <= '0;
		end else begin
			wq1_rgray <= rgray;
			wq2_rgray <= wq1_rgray;
		end
	end

	// Advance only on an accepted write
	assign wbinnext  = wbin + {{AW{1'b0}}, (i_wr && !o_wfull)};
	assign wgraynext = (wbinnext >> 1) ^ wbinnext;
	assign waddr     = wbin[AW-1:0];

	// Full when the next write pointer laps the read pointer
	// Top two Gray bits differ, the rest match
	assign wfull_next = (wgraynext == {~wq2_rgray[AW:AW-1], wq2_rgray[AW-2:0]});

	always_ff @(posedge i_wclk) begin
		if (!i_rst_n) begin
			wbin    <= '0;
			wgray   <= '0;
			o_wfull <= 1'b0;
		end else begin
			wbin    <= wbinnext;
			wgray   <= wgraynext;
			o_wfull <= wfull_next;
		end
	end

	always_ff @(posedge i_wclk) begin
		if (i_wr && !o_wfull)
			mem[waddr] <= i_wdata;
	end

	// Binary read pointer for credit accounting upstream
	assign o_rptr_sync = gray2bin(wq2_rgray);

	////////////////////
	// Read clock domain
	////////////////////

	// Write Gray pointer enters the read domain through two flops
	always_ff @(posedge i_rclk) begin
		if (!i_rrst_n) begin
			rq1_wgray <= '0;
			rq2_wgray <= '0;
		end else begin
			rq1_wgray <= wgray;
			rq2_wgray <= rq1_wgray;
		end
	end

	// Pop only when a word is present
	assign rbinnext  = rbin + {{AW{1'b0}}, (i_rd && o_rempty_)};
	assign rgraynext = (rbinnext >> 1) ^ rbinnext;
	assign raddr     = rbin[AW-1:0];

	// Data present when the pointers differ
	assign rempty__next = (rgraynext != rq2_wgray);

	always_ff @(posedge i_rclk) begin
		if (!i_rrst_n) begin
			rbin      <= '0;
			rgray     <= '0;
			o_rempty_ <= 1'b0;
		end else begin
			rbin      <= rbinnext;
			rgray     <= rgraynext;
			o_rempty_ <= rempty__next;
		end
	end

	// Unregistered read, the next stage holds the flop
	assign o_rdata = mem[raddr];

endmodule

`default_nettype wire

/* verilog/cdc_pkg.sv */
`default_nettype none

`include "cdc_consts.svh"

package cdc_pkg;

	////////////////////
	// Stream types
	////////////////////

	// One sample as seen at the bridge ports
	typedef struct packed {
		logic [`CDC_DATA_W-1:0] data;
	} sample_t;

	// FIFO word
	// Tag sits in the upper bits, sample below it
	typedef struct packed {
		logic [`CDC_TAG_W-1:0] tag;
		sample_t               sample;
	} cdc_word_t;

endpackage

`default_nettype wire

/* include/cdc_consts.svh */
`ifndef CDC_CONSTS_SVH
`define CDC_CONSTS_SVH

////////////////////
// Sample payload
////////////////////

// Width of one sample word
`define CDC_DATA_W 16

// Sequence tag width, wraps modulo 16
`define CDC_TAG_W 4

////////////////////
// Buffering and credits
////////////////////

// FIFO address width, depth is 1 << CDC_ASIZE
// Also the upstream credit count
`define CDC_ASIZE 4

// Credits the consumer grants after reset
`define CDC_DOWN_CREDITS 4

`endif
